// File: source/timerPkg.sv
// shared opcode, rate and state encodings plus instruction field positions for the timer bank
package timerPkg;

  ////////////////////////////////////////////////////////////
  // instruction opcodes, bits 31..29
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    opNop      = 3'b000,
    opSetClock = 3'b001,
    opEnClock  = 3'b010,
    opMode     = 3'b011,  // mode register removed, always nack
    opIllegal  = 3'b100,
    opSetAlarm = 3'b101,
    opSetTimer = 3'b110,
    opEnAlarm  = 3'b111
  } opcode_e;

  // counter rate, bits 23..22 of a set clock
  typedef enum logic [1:0] {
    rateDiv1 = 2'b00,  // every cycle
    rateDiv2 = 2'b01,  // every second cycle
    rateDiv4 = 2'b10,  // every fourth cycle
    rateBad  = 2'b11   // rejected by the decoder
  } rate_e;

  // assembler FSM
  typedef enum logic [1:0] {
    waitTop    = 2'b00,
    waitBottom = 2'b01,
    holdOut    = 2'b10
  } asmState_e;

  ////////////////////////////////////////////////////////////
  // data words
  ////////////////////////////////////////////////////////////
  typedef logic [15:0] halfWord_t;  // one host word
  typedef logic [31:0] instr_t;     // top and bottom joined

  ////////////////////////////////////////////////////////////
  // field positions inside instr_t
  ////////////////////////////////////////////////////////////
  parameter int OPCODE_LSB    = 29;  // opcode in 31..29
  parameter int CLK_IDX_LSB   = 25;  // clock index in 28..25
  parameter int ALARM_IDX_LSB = 24;  // alarm index in 28..24
  parameter int FLAG_BIT      = 23;  // enable or repeat
  parameter int RATE_LSB      = 22;  // rate in 23..22
  parameter int ALARM_CLK_LSB = 16;  // clock an alarm watches, 19..16
  parameter int VALUE_MSB     = 15;  // count, alarm value or interval in 15..0

endpackage

// File: source/instrAssembler.sv
// producer stage; joins two host words, top half first, into one instruction for the FIFO
`timescale 1ns/10ps

module instrAssembler (
  input  logic               clk_1x,
  input  logic               reset,
  input  timerPkg::halfWord_t hostWord,
  input  logic               hostValid,
  output logic               hostReady,
  output timerPkg::instr_t   instr,
  output logic               instrValid,
  input  logic               instrReady
);

  timerPkg::asmState_e state;
  timerPkg::halfWord_t topWord;  // held until the bottom word shows up
  logic                hostTake;

  assign hostTake   = hostValid && hostReady;
  assign hostReady  = (state != timerPkg::holdOut);  // no new word while holding
  assign instrValid = (state == timerPkg::holdOut);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      state <= timerPkg::waitTop;
    end else begin
      case (state)
        timerPkg::waitTop: begin
          if (hostTake) state <= timerPkg::waitBottom;
        end
        timerPkg::waitBottom: begin
          if (hostTake) state <= timerPkg::holdOut;  // instr valid next cycle
        end
        timerPkg::holdOut: begin
          if (instrReady) state <= timerPkg::waitTop;  // FIFO took it
        end
        default: state <= timerPkg::waitTop;
      endcase
    end
  end

  // payload, only loaded on an accepted host word
  always_ff @(posedge clk_1x) begin
    if (hostTake && state == timerPkg::waitTop) begin
      topWord <= hostWord;
    end
    if (hostTake && state == timerPkg::waitBottom) begin
      instr <= {topWord, hostWord};  // msw first
    end
  end

endmodule

// File: source/instrFifo.sv
// instruction buffer between assembler and decoder; circular store plus a registered output slot
`timescale 1ns/10ps

module instrFifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             clk_1x,
  input  logic             reset,
  input  timerPkg::instr_t instr,
  input  logic             instrValid,
  output logic             instrReady,
  output timerPkg::instr_t fifoInstr,
  output logic             fifoValid,
  input  logic             fifoReady
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  timerPkg::instr_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;     // words in mem without the slot
  logic             push;
  logic             slotLoad;  // move head of mem into the output slot

  // full once mem and the output slot together hold FIFO_DEPTH words
  assign instrReady = ((count + CNT_W'(fifoValid)) != CNT_W'(FIFO_DEPTH));
  assign push       = instrValid && instrReady;
  assign slotLoad   = (count != '0) && (!fifoValid || fifoReady);  // slot empty or leaving

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      fifoValid <= 1'b0;
    end else begin
      if (push) wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (slotLoad) rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, slotLoad})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push with pop
      endcase
      if (slotLoad) begin
        fifoValid <= 1'b1;
      end else if (fifoReady) begin
        fifoValid <= 1'b0;  // slot drained with nothing behind it
      end
    end
  end

  // storage and output data
  always_ff @(posedge clk_1x) begin
    if (push) mem[wrPtr] <= instr;
    if (slotLoad) fifoInstr <= mem[rdPtr];
  end

endmodule

// File: source/cmdDecoder.sv
// consumer front end; pops instructions, checks them, issues one-cycle write strobes, returns status
`timescale 1ns/10ps

module cmdDecoder #(
  parameter int NUM_CLOCKS  = 16,
  parameter int NUM_ALARMS  = 24,
  parameter int COUNT_WIDTH = 16,
  localparam int CLK_W = $clog2(NUM_CLOCKS),
  localparam int ALM_W = $clog2(NUM_ALARMS)
) (
  input  logic                   clk_1x,
  input  logic                   reset,
  input  timerPkg::instr_t       fifoInstr,
  input  logic                   fifoValid,
  output logic                   fifoReady,
  output logic                   statValid,
  output logic                   statAck,
  input  logic                   statReady,
  output logic                   clkSetEn,
  output logic                   clkEnableEn,
  output logic [CLK_W-1:0]       clkIdx,
  output timerPkg::rate_e        clkRate,
  output logic [COUNT_WIDTH-1:0] clkCount,
  output logic                   clkEnable,
  output logic                   almSetEn,
  output logic                   almTimerEn,
  output logic                   almEnableEn,
  output logic [ALM_W-1:0]       almIdx,
  output logic [CLK_W-1:0]       almClk,
  output logic                   almRepeat,
  output logic [COUNT_WIDTH-1:0] almValue,
  output logic                   almEnable
);

  localparam int ALM_FIELD_W = timerPkg::OPCODE_LSB - timerPkg::ALARM_IDX_LSB;  // 5 bits

  timerPkg::opcode_e      op;
  timerPkg::rate_e        rate;
  logic [ALM_FIELD_W-1:0] almField;
  logic                   take;
  logic                   opOk;

  assign op       = timerPkg::opcode_e'(fifoInstr[timerPkg::OPCODE_LSB +: 3]);
  assign rate     = timerPkg::rate_e'(fifoInstr[timerPkg::RATE_LSB +: 2]);
  assign almField = fifoInstr[timerPkg::ALARM_IDX_LSB +: ALM_FIELD_W];
  assign fifoReady = !statValid || statReady;  // pop only with the status path free
  assign take      = fifoValid && fifoReady;

  ////////////////////////////////////////////////////////////
  // legality check
  ////////////////////////////////////////////////////////////
  always_comb begin
    opOk = 1'b1;
    case (op)
      timerPkg::opNop:      opOk = 1'b1;
      timerPkg::opSetClock: opOk = (rate != timerPkg::rateBad);
      timerPkg::opEnClock:  opOk = 1'b1;
      timerPkg::opSetAlarm,
      timerPkg::opSetTimer,
      timerPkg::opEnAlarm:  opOk = (almField < NUM_ALARMS);  // index past the bank
      default:              opOk = 1'b0;  // opMode, opIllegal
    endcase
  end

  // status and strobes, one cycle after the pop
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      statValid   <= 1'b0;
      statAck     <= 1'b0;
      clkSetEn    <= 1'b0;
      clkEnableEn <= 1'b0;
      almSetEn    <= 1'b0;
      almTimerEn  <= 1'b0;
      almEnableEn <= 1'b0;
    end else begin
      clkSetEn    <= take && opOk && (op == timerPkg::opSetClock);
      clkEnableEn <= take && opOk && (op == timerPkg::opEnClock);
      almSetEn    <= take && opOk && (op == timerPkg::opSetAlarm);
      almTimerEn  <= take && opOk && (op == timerPkg::opSetTimer);
      almEnableEn <= take && opOk && (op == timerPkg::opEnAlarm);
      if (take) begin
        statValid <= 1'b1;
        statAck   <= opOk;
      end else if (statReady) begin
        statValid <= 1'b0;  // host took it
      end
    end
  end

  // strobe payload, meaningful only beside its enable
  always_ff @(posedge clk_1x) begin
    if (take) begin
      clkIdx    <= fifoInstr[timerPkg::CLK_IDX_LSB +: CLK_W];
      clkRate   <= rate;
      clkCount  <= COUNT_WIDTH'(fifoInstr[timerPkg::VALUE_MSB:0]);
      clkEnable <= fifoInstr[timerPkg::FLAG_BIT];
      almIdx    <= ALM_W'(almField);
      almClk    <= fifoInstr[timerPkg::ALARM_CLK_LSB +: CLK_W];
      almRepeat <= fifoInstr[timerPkg::FLAG_BIT];
      almValue  <= COUNT_WIDTH'(fifoInstr[timerPkg::VALUE_MSB:0]);
      almEnable <= fifoInstr[timerPkg::FLAG_BIT];
    end
  end

endmodule

// File: source/clockBank.sv
// counter array; shared prescaler gives per-counter tick enables at div1, div2 or div4
`timescale 1ns/10ps

module clockBank #(
  parameter int NUM_CLOCKS  = 16,
  parameter int COUNT_WIDTH = 16,
  localparam int CLK_W = $clog2(NUM_CLOCKS)
) (
  input  logic                              clk_1x,
  input  logic                              reset,
  input  logic                              clkSetEn,
  input  logic                              clkEnableEn,
  input  logic                              clkEnable,
  input  logic [CLK_W-1:0]                  clkIdx,
  input  timerPkg::rate_e                   clkRate,
  input  logic [COUNT_WIDTH-1:0]            clkCount,
  output logic [NUM_CLOCKS*COUNT_WIDTH-1:0] clockCounts,
  output logic [NUM_CLOCKS-1:0]             clockTicks
);

  logic [1:0]             prescale;  // free running from reset
  logic                   enable [NUM_CLOCKS];
  timerPkg::rate_e        rate   [NUM_CLOCKS];
  logic [COUNT_WIDTH-1:0] count  [NUM_CLOCKS];

  ////////////////////////////////////////////////////////////
  // tick enables
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      clockTicks[i] = enable[i] &&
                      ((rate[i] == timerPkg::rateDiv1) ||
                       (rate[i] == timerPkg::rateDiv2 && prescale[0]) ||
                       (rate[i] == timerPkg::rateDiv4 && prescale == 2'd3)) &&
                      !(clkSetEn && clkIdx == CLK_W'(i));  // load wins over the tick
      clockCounts[i*COUNT_WIDTH +: COUNT_WIDTH] = count[i];
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      prescale <= '0;
      for (int i = 0; i < NUM_CLOCKS; i++) begin
        enable[i] <= 1'b0;
        rate[i]   <= timerPkg::rateDiv1;
        count[i]  <= '0;
      end
    end else begin
      prescale <= prescale + 1'b1;
      for (int i = 0; i < NUM_CLOCKS; i++) begin
        if (clkSetEn && clkIdx == CLK_W'(i)) begin
          enable[i] <= 1'b1;  // set clock also starts it
          rate[i]   <= clkRate;
          count[i]  <= clkCount;
        end else begin
          if (clkEnableEn && clkIdx == CLK_W'(i)) enable[i] <= clkEnable;
          if (clockTicks[i]) count[i] <= count[i] + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/alarmBank.sv
// alarm and countdown timer array; compares each alarm to its clock and drives 2-cycle pulses
`timescale 1ns/10ps

module alarmBank #(
  parameter int NUM_CLOCKS  = 16,
  parameter int NUM_ALARMS  = 24,
  parameter int COUNT_WIDTH = 16,
  localparam int CLK_W = $clog2(NUM_CLOCKS),
  localparam int ALM_W = $clog2(NUM_ALARMS)
) (
  input  logic                              clk_1x,
  input  logic                              reset,
  input  logic                              almSetEn,
  input  logic                              almTimerEn,
  input  logic                              almEnableEn,
  input  logic                              almRepeat,
  input  logic                              almEnable,
  input  logic [ALM_W-1:0]                  almIdx,
  input  logic [CLK_W-1:0]                  almClk,
  input  logic [COUNT_WIDTH-1:0]            almValue,
  input  logic [NUM_CLOCKS*COUNT_WIDTH-1:0] clockCounts,
  input  logic [NUM_CLOCKS-1:0]             clockTicks,
  output logic [NUM_ALARMS-1:0]             alarmOut
);

  logic                   enable [NUM_ALARMS];
  logic                   repeatOn [NUM_ALARMS];  // re-arm after firing
  logic [CLK_W-1:0]       clkSel [NUM_ALARMS];
  logic [COUNT_WIDTH-1:0] value  [NUM_ALARMS];
  logic [1:0]             pulse  [NUM_ALARMS];    // cycles of output left
  logic [NUM_ALARMS-1:0]  match;
  logic [COUNT_WIDTH-1:0] timerBase;              // current count of the timer's clock

  assign timerBase = clockCounts[almClk*COUNT_WIDTH +: COUNT_WIDTH];

  ////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_ALARMS; i++) begin
      // fires on the tick that brings the counter onto the value
      match[i] = enable[i] && clockTicks[clkSel[i]] &&
                 (COUNT_WIDTH'(clockCounts[clkSel[i]*COUNT_WIDTH +: COUNT_WIDTH] + 1'b1)
                  == value[i]);
      alarmOut[i] = (pulse[i] != 2'd0);
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_ALARMS; i++) begin
        enable[i]   <= 1'b0;
        repeatOn[i] <= 1'b0;
        clkSel[i]   <= '0;
        value[i]    <= '0;
        pulse[i]    <= 2'd0;
      end
    end else begin
      for (int i = 0; i < NUM_ALARMS; i++) begin
        // pulse runs on its own, a new set does not cut it short
        if (match[i]) begin
          pulse[i] <= 2'd2;
        end else if (pulse[i] != 2'd0) begin
          pulse[i] <= pulse[i] - 1'b1;
        end
        if (almSetEn && almIdx == ALM_W'(i)) begin
          enable[i]   <= 1'b1;
          repeatOn[i] <= almRepeat;
          clkSel[i]   <= almClk;
          value[i]    <= almValue;
        end else if (almTimerEn && almIdx == ALM_W'(i)) begin
          enable[i]   <= 1'b1;
          repeatOn[i] <= 1'b0;                  // timers fire once
          clkSel[i]   <= almClk;
          value[i]    <= almValue + timerBase;  // expiry relative to now
        end else if (almEnableEn && almIdx == ALM_W'(i)) begin
          enable[i] <= almEnable;
        end else if (match[i] && !repeatOn[i]) begin
          enable[i] <= 1'b0;  // one-shot done
        end
      end
    end
  end

endmodule

// File: source/timerTop.sv
// top level of the clock and alarm bank; sets the sizes and wires producer, FIFO and consumer
`timescale 1ns/10ps

module timerTop #(
  parameter int NUM_CLOCKS  = 16,
  parameter int NUM_ALARMS  = 24,
  parameter int COUNT_WIDTH = 16,
  parameter int FIFO_DEPTH  = 4
) (
  input  logic                clk_1x,
  input  logic                reset,
  input  timerPkg::halfWord_t hostWord,
  input  logic                hostValid,
  output logic                hostReady,
  output logic                statValid,
  output logic                statAck,
  input  logic                statReady,
  output logic [NUM_ALARMS-1:0] alarmOut
);

  localparam int CLK_W = $clog2(NUM_CLOCKS);
  localparam int ALM_W = $clog2(NUM_ALARMS);

  // assembler to FIFO
  timerPkg::instr_t instr;
  logic             instrValid;
  logic             instrReady;
  // FIFO to decoder
  timerPkg::instr_t fifoInstr;
  logic             fifoValid;
  logic             fifoReady;
  // decoder strobes
  logic                   clkSetEn;
  logic                   clkEnableEn;
  logic                   clkEnable;
  logic [CLK_W-1:0]       clkIdx;
  timerPkg::rate_e        clkRate;
  logic [COUNT_WIDTH-1:0] clkCount;
  logic                   almSetEn;
  logic                   almTimerEn;
  logic                   almEnableEn;
  logic                   almRepeat;
  logic                   almEnable;
  logic [ALM_W-1:0]       almIdx;
  logic [CLK_W-1:0]       almClk;
  logic [COUNT_WIDTH-1:0] almValue;
  // clocks to alarms
  logic [NUM_CLOCKS*COUNT_WIDTH-1:0] clockCounts;
  logic [NUM_CLOCKS-1:0]             clockTicks;

  ////////////////////////////////////////////////////////////
  // producer, buffer, consumer
  ////////////////////////////////////////////////////////////
  instrAssembler u_asm (
    .clk_1x(clk_1x), .reset(reset),
    .hostWord(hostWord), .hostValid(hostValid), .hostReady(hostReady),
    .instr(instr), .instrValid(instrValid), .instrReady(instrReady)
  );

  instrFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk_1x(clk_1x), .reset(reset),
    .instr(instr), .instrValid(instrValid), .instrReady(instrReady),
    .fifoInstr(fifoInstr), .fifoValid(fifoValid), .fifoReady(fifoReady)
  );

  cmdDecoder #(
    .NUM_CLOCKS(NUM_CLOCKS), .NUM_ALARMS(NUM_ALARMS), .COUNT_WIDTH(COUNT_WIDTH)
  ) u_dec (
    .clk_1x(clk_1x), .reset(reset),
    .fifoInstr(fifoInstr), .fifoValid(fifoValid), .fifoReady(fifoReady),
    .statValid(statValid), .statAck(statAck), .statReady(statReady),
    .clkSetEn(clkSetEn), .clkEnableEn(clkEnableEn), .clkIdx(clkIdx),
    .clkRate(clkRate), .clkCount(clkCount), .clkEnable(clkEnable),
    .almSetEn(almSetEn), .almTimerEn(almTimerEn), .almEnableEn(almEnableEn),
    .almIdx(almIdx), .almClk(almClk), .almRepeat(almRepeat),
    .almValue(almValue), .almEnable(almEnable)
  );

  clockBank #(.NUM_CLOCKS(NUM_CLOCKS), .COUNT_WIDTH(COUNT_WIDTH)) u_clocks (
    .clk_1x(clk_1x), .reset(reset),
    .clkSetEn(clkSetEn), .clkEnableEn(clkEnableEn), .clkEnable(clkEnable),
    .clkIdx(clkIdx), .clkRate(clkRate), .clkCount(clkCount),
    .clockCounts(clockCounts), .clockTicks(clockTicks)
  );

  alarmBank #(
    .NUM_CLOCKS(NUM_CLOCKS), .NUM_ALARMS(NUM_ALARMS), .COUNT_WIDTH(COUNT_WIDTH)
  ) u_alarms (
    .clk_1x(clk_1x), .reset(reset),
    .almSetEn(almSetEn), .almTimerEn(almTimerEn), .almEnableEn(almEnableEn),
    .almRepeat(almRepeat), .almEnable(almEnable), .almIdx(almIdx),
    .almClk(almClk), .almValue(almValue),
    .clockCounts(clockCounts), .clockTicks(clockTicks), .alarmOut(alarmOut)
  );

endmodule

// File: verif/timerTop_asserts.sv
// handshake and alarm pulse assertions, bound into timerTop from the testbench
`timescale 1ns/10ps

module timerTop_asserts #(
  parameter int NUM_ALARMS = 24
) (
  input logic                  clk_1x,
  input logic                  reset,
  input timerPkg::halfWord_t   hostWord,
  input logic                  hostValid,
  input logic                  hostReady,
  input logic                  statValid,
  input logic                  statAck,
  input logic                  statReady,
  input logic [NUM_ALARMS-1:0] alarmOut
);

  ////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////
  // host holds its word until taken
  hostWordStable: assert property (@(posedge clk_1x) disable iff (reset)
    (hostValid && !hostReady) |=> $stable(hostWord))
    else $error("hostWord changed while waiting on hostReady");

  statusStable: assert property (@(posedge clk_1x) disable iff (reset)
    (statValid && !statReady) |=> (statValid && $stable(statAck)))
    else $error("status dropped or changed before statReady");

  // every alarm pulse is two cycles wide
  for (genvar i = 0; i < NUM_ALARMS; i++) begin : g_pulse
    pulseWidth: assert property (@(posedge clk_1x) disable iff (reset)
      $rose(alarmOut[i]) |=> (alarmOut[i] ##1 !alarmOut[i]))
      else $error("alarmOut[%0d] pulse not exactly 2 cycles", i);
  end

endmodule

// File: verif/tbTimer.sv
// testbench for timerTop; directed tests through the host and status handshakes, run as top tbTimer
`timescale 1ns/10ps

module tbTimer;

  localparam int NUM_ALARMS = 24;
  // test windows plus about 20 cycles per instruction and some slack
  localparam int TIMEOUT_CYCLES = 5*40 + 6*40 + 5*30 + 2*80 + 30*20 + 1000;

  logic                  clk_1x;
  logic                  reset;
  timerPkg::halfWord_t   hostWord;
  logic                  hostValid;
  logic                  hostReady;
  logic                  statValid;
  logic                  statAck;
  logic                  statReady;
  logic [NUM_ALARMS-1:0] alarmOut;

  int seed = 66751;
  int valueErrors = 0;   // wrong values
  int otherErrors = 0;   // protocol or timing trouble
  int cycle = 0;         // rising edges since start
  int statCycle;         // edge at which the last status showed up
  int riseCount  [NUM_ALARMS];
  int firstRise  [NUM_ALARMS];
  int pulseWidth [NUM_ALARMS];  // width of the first pulse only
  logic [NUM_ALARMS-1:0] sawMask;

  timerTop #(.NUM_ALARMS(NUM_ALARMS)) u_dut (
    .clk_1x(clk_1x), .reset(reset),
    .hostWord(hostWord), .hostValid(hostValid), .hostReady(hostReady),
    .statValid(statValid), .statAck(statAck), .statReady(statReady),
    .alarmOut(alarmOut)
  );

  bind timerTop timerTop_asserts #(.NUM_ALARMS(NUM_ALARMS)) u_asserts (
    .clk_1x(clk_1x), .reset(reset),
    .hostWord(hostWord), .hostValid(hostValid), .hostReady(hostReady),
    .statValid(statValid), .statAck(statAck), .statReady(statReady),
    .alarmOut(alarmOut)
  );

  initial begin
    clk_1x = 1'b0;
    forever #4 clk_1x = ~clk_1x;  // 8 ns
  end

  always @(posedge clk_1x) cycle <= cycle + 1;

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_1x);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic checkAck(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic checkAlarms(input string name, input logic [NUM_ALARMS-1:0] actual,
                             input logic [NUM_ALARMS-1:0] expected);
    if (actual !== expected) begin
      valueErrors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // lo == hi for an exact count
  task automatic checkCount(input string name, input int actual, input int lo, input int hi);
    if (actual < lo || actual > hi) begin
      valueErrors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h..0x%0h", name, actual, lo, hi);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // instruction builders using the timerPkg field layout
  ////////////////////////////////////////////////////////////
  function automatic timerPkg::instr_t makeOp(input timerPkg::opcode_e op);
    timerPkg::instr_t w;
    w = '0;
    w[timerPkg::OPCODE_LSB +: 3] = op;
    return w;
  endfunction

  function automatic timerPkg::instr_t makeSetClock(input int idx, input timerPkg::rate_e rate,
                                                    input logic [15:0] count);
    timerPkg::instr_t w;
    w = makeOp(timerPkg::opSetClock);
    w[timerPkg::CLK_IDX_LSB +: 4] = idx[3:0];
    w[timerPkg::RATE_LSB +: 2]    = rate;
    w[15:0]                       = count;
    return w;
  endfunction

  function automatic timerPkg::instr_t makeEnClock(input int idx, input logic en);
    timerPkg::instr_t w;
    w = makeOp(timerPkg::opEnClock);
    w[timerPkg::CLK_IDX_LSB +: 4] = idx[3:0];
    w[timerPkg::FLAG_BIT]         = en;
    return w;
  endfunction

  // set alarm and countdown timer share a layout apart from the opcode
  function automatic timerPkg::instr_t makeAlarm(input timerPkg::opcode_e op, input int idx,
                                                 input logic rpt, input int clkSel,
                                                 input logic [15:0] value);
    timerPkg::instr_t w;
    w = makeOp(op);
    w[timerPkg::ALARM_IDX_LSB +: 5] = idx[4:0];
    w[timerPkg::FLAG_BIT]           = rpt;
    w[timerPkg::ALARM_CLK_LSB +: 4] = clkSel[3:0];
    w[15:0]                         = value;
    return w;
  endfunction

  function automatic logic [NUM_ALARMS-1:0] alarmBit(input int idx);
    return NUM_ALARMS'(1) << idx;
  endfunction

  ////////////////////////////////////////////////////////////
  // handshakes entered and left on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic sendWord(input timerPkg::halfWord_t w);
    hostWord  = w;
    hostValid = 1'b1;
    while (!hostReady) @(negedge clk_1x);  // hostReady only moves on a rising edge
    @(negedge clk_1x);        // taken on the edge just passed
    hostValid = 1'b0;
  endtask

  task automatic sendInstr(input timerPkg::instr_t w);
    sendWord(w[31:16]);  // msw first
    sendWord(w[15:0]);
  endtask

  task automatic readStatus(output logic ack);
    statReady = 1'b1;
    while (!statValid) @(negedge clk_1x);
    ack       = statAck;
    statCycle = cycle;
    @(negedge clk_1x);
    statReady = 1'b0;
  endtask

  task automatic issue(input timerPkg::instr_t w, input logic expAck, input string name);
    logic ack;
    sendInstr(w);
    readStatus(ack);
    checkAck({"statAck for ", name}, ack, expAck);
  endtask

  // samples alarmOut on falling edges, keeps rises and first pulse width per bit
  task automatic watchAlarms(input int window);
    logic [NUM_ALARMS-1:0] prev;
    prev    = alarmOut;
    sawMask = '0;
    for (int i = 0; i < NUM_ALARMS; i++) begin
      riseCount[i]  = 0;
      firstRise[i]  = -1;
      pulseWidth[i] = 0;
    end
    repeat (window) begin
      @(negedge clk_1x);
      sawMask |= alarmOut;
      for (int i = 0; i < NUM_ALARMS; i++) begin
        if (alarmOut[i] && !prev[i]) begin
          riseCount[i]++;
          if (riseCount[i] == 1) firstRise[i] = cycle;
        end
        if (alarmOut[i] && riseCount[i] == 1) pulseWidth[i]++;
      end
      prev = alarmOut;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic testDiv1Alarm();
    logic [15:0] c;
    c = $random(seed) & 16'h3fff;  // keep clear of wrap
    issue(makeSetClock(2, timerPkg::rateDiv1, c), 1'b1, "set clock 2");
    issue(makeAlarm(timerPkg::opSetAlarm, 4, 1'b0, 2, c + 16'd40), 1'b1, "set alarm 4");
    watchAlarms(5 * 40);
    checkAlarms("alarmOut bits seen", sawMask, alarmBit(4));
    checkCount("alarm 4 rises", riseCount[4], 1, 1);
    checkCount("alarm 4 pulse width", pulseWidth[4], 2, 2);
  endtask

  task automatic testRateAlarms();
    logic [15:0] s;
    s = $random(seed) & 16'h3fff;
    issue(makeSetClock(6, timerPkg::rateDiv2, s), 1'b1, "set clock 6");
    issue(makeSetClock(7, timerPkg::rateDiv4, s), 1'b1, "set clock 7");
    issue(makeAlarm(timerPkg::opSetAlarm, 8, 1'b0, 6, s + 16'd40), 1'b1, "set alarm 8");
    issue(makeAlarm(timerPkg::opSetAlarm, 9, 1'b0, 7, s + 16'd40), 1'b1, "set alarm 9");
    watchAlarms(6 * 40);
    checkAlarms("alarmOut bits seen", sawMask, alarmBit(8) | alarmBit(9));
    checkCount("alarm 8 rises", riseCount[8], 1, 1);
    checkCount("alarm 9 rises", riseCount[9], 1, 1);
    checkCount("div4 minus div2 fire gap", firstRise[9] - firstRise[8], 40, 3 * 40 + 4);
  endtask

  task automatic testCountdown();
    int sentAt;
    issue(makeAlarm(timerPkg::opSetTimer, 10, 1'b0, 2, 16'd30), 1'b1, "set timer 10");
    sentAt = statCycle;
    watchAlarms(5 * 30);
    checkAlarms("alarmOut bits seen", sawMask, alarmBit(10));
    checkCount("timer 10 rises", riseCount[10], 1, 1);
    checkCount("timer 10 delay", firstRise[10] - sentAt, 30, 4 * 30 + 4);
  endtask

  task automatic testDisabledAndNack();
    logic [15:0] d;
    d = $random(seed) & 16'h3fff;
    issue(makeSetClock(3, timerPkg::rateDiv1, d), 1'b1, "set clock 3");
    issue(makeSetClock(4, timerPkg::rateDiv1, d), 1'b1, "set clock 4");
    issue(makeEnClock(4, 1'b0), 1'b1, "disable clock 4");
    issue(makeAlarm(timerPkg::opSetAlarm, 11, 1'b0, 3, d + 16'd80), 1'b1, "set alarm 11");
    issue(makeAlarm(timerPkg::opEnAlarm, 11, 1'b0, 0, 16'd0), 1'b1, "disable alarm 11");
    issue(makeAlarm(timerPkg::opSetAlarm, 12, 1'b0, 4, d + 16'd80), 1'b1, "set alarm 12");
    watchAlarms(2 * 80);  // clock 3 passes d+80 in here
    checkAlarms("alarmOut bits seen", sawMask, '0);
    // rejected encodings
    issue(makeOp(timerPkg::opMode), 1'b0, "opcode 011");
    issue(makeOp(timerPkg::opIllegal), 1'b0, "opcode 100");
    issue(makeSetClock(5, timerPkg::rateBad, 16'd0), 1'b0, "rate 11");
    issue(makeAlarm(timerPkg::opSetAlarm, 30, 1'b0, 0, 16'd5), 1'b0, "alarm index 30");
    issue(makeOp(timerPkg::opNop), 1'b1, "nop");
  endtask

  task automatic testBackPressure();
    timerPkg::instr_t cmds [6];
    logic             expAck [6];
    logic             ack;
    cmds[0]   = makeOp(timerPkg::opNop);
    expAck[0] = 1'b1;
    cmds[1]   = makeOp(timerPkg::opMode);
    expAck[1] = 1'b0;
    cmds[2]   = makeSetClock(5, timerPkg::rateDiv1, 16'd0);
    expAck[2] = 1'b1;
    cmds[3]   = makeSetClock(5, timerPkg::rateBad, 16'd0);
    expAck[3] = 1'b0;
    cmds[4]   = makeAlarm(timerPkg::opEnAlarm, 30, 1'b0, 0, 16'd0);
    expAck[4] = 1'b0;
    cmds[5]   = makeAlarm(timerPkg::opEnAlarm, 3, 1'b0, 0, 16'd0);
    expAck[5] = 1'b1;
    statReady = 1'b0;  // status path blocked
    for (int i = 0; i < 6; i++) sendInstr(cmds[i]);
    repeat (10) @(negedge clk_1x);
    checkAck("statValid while blocked", statValid, 1'b1);
    // one status pending and the FIFO full, so the sixth stays in the assembler
    if (hostReady !== 1'b0) begin
      otherErrors++;
      $display("hostReady stayed high although the status path was blocked and the FIFO full");
    end
    for (int i = 0; i < 6; i++) begin
      readStatus(ack);
      checkAck($sformatf("statAck for queued instruction %0d", i), ack, expAck[i]);
    end
    repeat (10) @(negedge clk_1x);
    checkAck("statValid after drain", statValid, 1'b0);  // nothing extra
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    reset     = 1'b1;
    hostWord  = '0;
    hostValid = 1'b0;
    statReady = 1'b0;
    repeat (3) @(posedge clk_1x);
    @(negedge clk_1x);
    reset = 1'b0;
    @(negedge clk_1x);
    testDiv1Alarm();
    testRateAlarms();
    testCountdown();
    testDisabledAndNack();
    testBackPressure();
    $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
source/timerPkg.sv
source/instrAssembler.sv
source/instrFifo.sv
source/cmdDecoder.sv
source/clockBank.sv
source/alarmBank.sv
source/timerTop.sv
verif/timerTop_asserts.sv
verif/tbTimer.sv

// File: Bender.yml
package:
  name: timer_bank

sources:
  - files:
      - source/timerPkg.sv
      - source/instrAssembler.sv
      - source/instrFifo.sv
      - source/cmdDecoder.sv
      - source/clockBank.sv
      - source/alarmBank.sv
      - source/timerTop.sv
  - target: test
    files:
      - verif/timerTop_asserts.sv
      - verif/tbTimer.sv
